// File: sim.f
rtl/dss_pkg.sv
rtl/cplx_if.sv
rtl/delay_line.sv
rtl/coeff_ram.sv
rtl/complex_mult.sv
rtl/resize_data.sv
rtl/dss_synthesis.sv
tests/dss_synthesis_properties.sv
tests/dss_synthesis_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dss_synthesis_tb \
    -Mdir obj_dir \
    -f sim.f

sim_out=$(./obj_dir/Vdss_synthesis_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// File: tests/dss_synthesis_tb.sv
`default_nettype none

module dss_synthesis_tb;

    import dss_pkg::*;

    localparam int VECTOR_LEN  = 16;
    localparam int ADDR_W      = $clog2(VECTOR_LEN);
    localparam int DIN_W       = default_din_width;
    localparam int COEFF_W     = default_coeff_width;
    localparam int DOUT_W      = default_dout_width;
    localparam int DROP_BITS   = default_din_point + default_coeff_point - default_dout_point;
    localparam int OUT_MAX     = (1 << (DOUT_W - 1)) - 1;
    localparam int OUT_MIN     = -(1 << (DOUT_W - 1));
    localparam int unsigned RAND_SEED = 32'h7991_1a0f;

    localparam int RESET_CYCLES    = 3;
    localparam int LOAD_CYCLES     = VECTOR_LEN;
    localparam int RANDOM_CYCLES   = 240;
    localparam int SAT_LOAD_CYCLES = VECTOR_LEN;
    localparam int SAT_CYCLES      = 64;
    localparam int REWRITE_CYCLES  = 120;
    localparam int DRAIN_CYCLES    = PIPE_LATENCY + 3;
    localparam int MAX_CYCLES      = RESET_CYCLES + LOAD_CYCLES + RANDOM_CYCLES
                                   + SAT_LOAD_CYCLES + SAT_CYCLES + REWRITE_CYCLES
                                   + DRAIN_CYCLES + 64;

    typedef struct packed {
        int   re;
        int   im;
        logic valid;
        logic sync;
        logic warn;
    } expect_t;

    logic                      clk;
    logic                      cnt_rst;
    logic                      sync_in;
    logic signed [DIN_W-1:0]   din_re;
    logic signed [DIN_W-1:0]   din_im;
    logic                      coeff_we;
    logic        [ADDR_W-1:0]  coeff_waddr;
    logic signed [COEFF_W-1:0] coeff_wdata_re;
    logic signed [COEFF_W-1:0] coeff_wdata_im;
    logic signed [DOUT_W-1:0]  dout_re;
    logic signed [DOUT_W-1:0]  dout_im;
    logic                      dout_valid;
    logic                      sync_out;
    logic                      cast_warning;

    // model state
    int      coeff_re_m [VECTOR_LEN];
    int      coeff_im_m [VECTOR_LEN];
    int      model_bin;
    bit      model_run;
    int      sync_gap;
    expect_t exp_q [$];

    int          errors;
    int          checks;
    int          cycle_count = 0;
    string       phase_name;
    int unsigned seed_dummy;

    dss_synthesis #(
        .VECTOR_LEN (VECTOR_LEN)
    ) uut (
        .clk            (clk),
        .cnt_rst        (cnt_rst),
        .sync_in        (sync_in),
        .din_re         (din_re),
        .din_im         (din_im),
        .coeff_we       (coeff_we),
        .coeff_waddr    (coeff_waddr),
        .coeff_wdata_re (coeff_wdata_re),
        .coeff_wdata_im (coeff_wdata_im),
        .dout_re        (dout_re),
        .dout_im        (dout_im),
        .dout_valid     (dout_valid),
        .sync_out       (sync_out),
        .cast_warning   (cast_warning)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input longint expected, input longint actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("Fail %s %s: expected %0d, actual %0d", phase_name, what, expected, actual);
        end
    endtask

    // divide by 2**DROP_BITS, rounding toward minus infinity
    function automatic longint floor_shift(input longint x);
        longint div;
        longint q;
        div = longint'(1) << DROP_BITS;
        q = x / div;
        if ((x % div != 0) && (x < 0)) begin
            q = q - 1;
        end
        return q;
    endfunction

    function automatic int saturate(input longint x);
        if (x > OUT_MAX) begin
            return OUT_MAX;
        end
        if (x < OUT_MIN) begin
            return OUT_MIN;
        end
        return int'(x);
    endfunction

    function automatic int rand_sample();
        int v;
        v = $urandom % 65536;
        return v - 32768;
    endfunction

    // about plus or minus one half in Q2.14
    function automatic int rand_coeff();
        int v;
        v = $urandom % 16384;
        return v - 8192;
    endfunction

    function automatic int big_value();
        int v;
        case ($urandom % 4)
            0: v = 32767;
            1: v = -32768;
            2: v = 30000 + int'($urandom % 2768);
            default: v = -(30000 + int'($urandom % 2768));
        endcase
        return v;
    endfunction

    task automatic pick_sync(output bit s);
        if (sync_gap == 0) begin
            s = 1'b1;
            sync_gap = 4 + int'($urandom % 32);
        end else begin
            s = 1'b0;
            sync_gap--;
        end
    endtask

    // check the outputs due now, then drive one sample and predict its output
    task automatic run_cycle(input bit sync, input bit we, input int waddr,
                             input int wre, input int wim, input int sre, input int sim);
        expect_t got;
        expect_t nxt;
        int      idx;
        longint  pre;
        longint  pim;
        longint  fre;
        longint  fim;
        got = exp_q.pop_front();
        check_value("dout_valid", got.valid, dout_valid);
        check_value("sync_out", got.sync, sync_out);
        check_value("cast_warning", got.warn, cast_warning);
        if (got.valid) begin
            check_value("dout_re", got.re, dout_re);
            check_value("dout_im", got.im, dout_im);
        end

        sync_in        = sync;
        din_re         = sre[DIN_W-1:0];
        din_im         = sim[DIN_W-1:0];
        coeff_we       = we;
        coeff_waddr    = waddr[ADDR_W-1:0];
        coeff_wdata_re = wre[COEFF_W-1:0];
        coeff_wdata_im = wim[COEFF_W-1:0];

        idx = sync ? 0 : model_bin;
        if (sync) begin
            model_run = 1'b1;
        end
        pre = longint'(sre) * coeff_re_m[idx] - longint'(sim) * coeff_im_m[idx];
        pim = longint'(sre) * coeff_im_m[idx] + longint'(sim) * coeff_re_m[idx];
        fre = floor_shift(pre);
        fim = floor_shift(pim);
        nxt.re    = saturate(fre);
        nxt.im    = saturate(fim);
        nxt.valid = model_run;
        nxt.sync  = sync;
        nxt.warn  = model_run && ((fre != nxt.re) || (fim != nxt.im));
        exp_q.push_back(nxt);
        model_bin = (idx + 1) % VECTOR_LEN;

        // the read of this sample sees the old word
        if (we) begin
            coeff_re_m[waddr] = wre;
            coeff_im_m[waddr] = wim;
        end
        @(negedge clk);
    endtask

    initial begin
        bit      s;
        bit      we;
        int      sre;
        int      sim;
        expect_t idle;
        seed_dummy     = $urandom(RAND_SEED);
        errors         = 0;
        checks         = 0;
        cnt_rst        = 1'b1;
        sync_in        = 1'b0;
        din_re         = '0;
        din_im         = '0;
        coeff_we       = 1'b0;
        coeff_waddr    = '0;
        coeff_wdata_re = '0;
        coeff_wdata_im = '0;
        model_bin      = 0;
        model_run      = 1'b0;
        sync_gap       = 0;
        phase_name     = "reset";
        for (int i = 0; i < VECTOR_LEN; i++) begin
            coeff_re_m[i] = 0;
            coeff_im_m[i] = 0;
        end
        // outputs stay low while the pipeline fills after reset
        idle = '0;
        for (int i = 0; i < PIPE_LATENCY; i++) begin
            exp_q.push_back(idle);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        cnt_rst = 1'b0;

        phase_name = "load";
        for (int i = 0; i < LOAD_CYCLES; i++) begin
            run_cycle(1'b0, 1'b1, i, rand_coeff(), rand_coeff(), rand_sample(), rand_sample());
        end

        phase_name = "random";
        sync_gap = 0;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            pick_sync(s);
            run_cycle(s, 1'b0, 0, 0, 0, rand_sample(), rand_sample());
        end

        phase_name = "sat_load";
        for (int i = 0; i < SAT_LOAD_CYCLES; i++) begin
            pick_sync(s);
            run_cycle(s, 1'b1, i, big_value(), big_value(), big_value(), big_value());
        end

        phase_name = "saturate";
        for (int i = 0; i < SAT_CYCLES; i++) begin
            pick_sync(s);
            // a few small samples stay inside the output range
            sre = ($urandom % 4 == 0) ? rand_sample() / 64 : big_value();
            sim = ($urandom % 4 == 0) ? rand_sample() / 64 : big_value();
            run_cycle(s, 1'b0, 0, 0, 0, sre, sim);
        end

        phase_name = "rewrite";
        for (int i = 0; i < REWRITE_CYCLES; i++) begin
            pick_sync(s);
            we = ($urandom % 3 == 0);
            run_cycle(s, we, int'($urandom % VECTOR_LEN), rand_coeff(), rand_coeff(),
                      rand_sample(), rand_sample());
        end

        phase_name = "drain";
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            run_cycle(1'b0, 1'b0, 0, 0, 0, 0, 0);
        end

        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/dss_synthesis_properties.sv
`default_nettype none

module dss_synthesis_properties (
    input wire clk,
    input wire cnt_rst,
    input wire sync_in,
    input wire sync_out,
    input wire dout_valid,
    input wire cast_warning
);

    import dss_pkg::*;

    // cycles since reset, capped at the pipeline depth
    int warm_cnt;

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            warm_cnt <= 0;
        end else if (warm_cnt < PIPE_LATENCY) begin
            warm_cnt <= warm_cnt + 1;
        end
    end

    sync_delay: assert property (@(posedge clk) disable iff (cnt_rst)
        (warm_cnt == PIPE_LATENCY) |-> (sync_out == $past(sync_in, PIPE_LATENCY)))
        else $error("sync_out is not sync_in delayed by the pipeline latency");

    valid_hold: assert property (@(posedge clk) disable iff (cnt_rst)
        $fell(dout_valid) |-> $past(cnt_rst))
        else $error("dout_valid fell without a reset");

    warn_in_valid: assert property (@(posedge clk) disable iff (cnt_rst)
        cast_warning |-> dout_valid)
        else $error("cast_warning is high while dout_valid is low");

endmodule

bind dss_synthesis dss_synthesis_properties props (
    .clk          (clk),
    .cnt_rst      (cnt_rst),
    .sync_in      (sync_in),
    .sync_out     (sync_out),
    .dout_valid   (dout_valid),
    .cast_warning (cast_warning)
);

`default_nettype wire

// File: rtl/dss_synthesis.sv
`default_nettype none

module dss_synthesis #(
    parameter int DIN_WIDTH   = dss_pkg::default_din_width,
    parameter int DIN_POINT   = dss_pkg::default_din_point,
    parameter int COEFF_WIDTH = dss_pkg::default_coeff_width,
    parameter int COEFF_POINT = dss_pkg::default_coeff_point,
    parameter int VECTOR_LEN  = 16,
    parameter int SHIFT       = 0,
    parameter int DOUT_WIDTH  = dss_pkg::default_dout_width,
    parameter int DOUT_POINT  = dss_pkg::default_dout_point
) (
    input  wire                               clk,
    input  wire                               cnt_rst,

    input  wire                               sync_in,
    input  wire signed [DIN_WIDTH-1:0]        din_re,
    input  wire signed [DIN_WIDTH-1:0]        din_im,

    input  wire                               coeff_we,
    input  wire        [$clog2(VECTOR_LEN)-1:0] coeff_waddr,
    input  wire signed [COEFF_WIDTH-1:0]      coeff_wdata_re,
    input  wire signed [COEFF_WIDTH-1:0]      coeff_wdata_im,

    output logic signed [DOUT_WIDTH-1:0]      dout_re,
    output logic signed [DOUT_WIDTH-1:0]      dout_im,
    output logic                              dout_valid,
    output logic                              sync_out,
    output logic                              cast_warning
);

    import dss_pkg::*;

    localparam int ADDR_WIDTH = $clog2(VECTOR_LEN);
    localparam int PROD_WIDTH = DIN_WIDTH + COEFF_WIDTH + 1;
    localparam int PROD_POINT = DIN_POINT + COEFF_POINT;

    typedef struct packed {
        logic signed [DIN_WIDTH-1:0] re;
        logic signed [DIN_WIDTH-1:0] im;
    } sample_t;

    logic [ADDR_WIDTH-1:0] bin_cnt;
    logic [ADDR_WIDTH-1:0] bin_idx;

    logic signed [COEFF_WIDTH-1:0] coeff_re;
    logic signed [COEFF_WIDTH-1:0] coeff_im;

    sample_t sample_in;
    sample_t sample_d;
    logic    sync_d;
    logic    run_lvl;

    cplx_if #(.WIDTH(DIN_WIDTH))  mult_in ();
    cplx_if #(.WIDTH(PROD_WIDTH)) prod ();

    // bin of the sample on the input this cycle, sync forces bin 0
    assign bin_idx = sync_in ? '0 : bin_cnt;

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            bin_cnt <= '0;
        end else begin
            bin_cnt <= bin_idx + 1'b1;
        end
    end

    coeff_ram #(
        .VECTOR_LEN  (VECTOR_LEN),
        .COEFF_WIDTH (COEFF_WIDTH)
    ) coeff_mem (
        .clk      (clk),
        .we       (coeff_we),
        .waddr    (coeff_waddr),
        .wdata_re (coeff_wdata_re),
        .wdata_im (coeff_wdata_im),
        .raddr    (bin_idx),
        .rdata_re (coeff_re),
        .rdata_im (coeff_im)
    );

    // hold the sample until its coefficient is out of the memory
    assign sample_in = {din_re, din_im};

    delay_line #(
        .payload_t (sample_t),
        .DEPTH     (READ_LATENCY)
    ) sample_dly (
        .clk  (clk),
        .din  (sample_in),
        .dout (sample_d)
    );

    delay_line #(
        .payload_t (logic),
        .DEPTH     (READ_LATENCY)
    ) sync_dly (
        .clk  (clk),
        .din  (sync_in),
        .dout (sync_d)
    );

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            run_lvl <= 1'b0;
        end else if (sync_d) begin
            run_lvl <= 1'b1;
        end
    end

    // valid already on the first aligned sync
    assign mult_in.re    = sample_d.re;
    assign mult_in.im    = sample_d.im;
    assign mult_in.sync  = sync_d;
    assign mult_in.valid = run_lvl | sync_d;

    complex_mult #(
        .DIN_WIDTH   (DIN_WIDTH),
        .COEFF_WIDTH (COEFF_WIDTH)
    ) mult (
        .clk      (clk),
        .cnt_rst  (cnt_rst),
        .a        (mult_in),
        .coeff_re (coeff_re),
        .coeff_im (coeff_im),
        .p        (prod)
    );

    resize_data #(
        .DIN_WIDTH  (PROD_WIDTH),
        .DIN_POINT  (PROD_POINT),
        .SHIFT      (SHIFT),
        .DOUT_WIDTH (DOUT_WIDTH),
        .DOUT_POINT (DOUT_POINT)
    ) resize (
        .clk        (clk),
        .cnt_rst    (cnt_rst),
        .d          (prod),
        .dout_re    (dout_re),
        .dout_im    (dout_im),
        .dout_valid (dout_valid),
        .sync_out   (sync_out),
        .warning    (cast_warning)
    );

endmodule

`default_nettype wire

// File: rtl/resize_data.sv
`default_nettype none

module resize_data #(
    parameter int DIN_WIDTH  = 33,
    parameter int DIN_POINT  = 29,
    parameter int SHIFT      = 0,
    parameter int DOUT_WIDTH = 16,
    parameter int DOUT_POINT = 15
) (
    input  wire                          clk,
    input  wire                          cnt_rst,
    cplx_if.dst                          d,
    output logic signed [DOUT_WIDTH-1:0] dout_re,
    output logic signed [DOUT_WIDTH-1:0] dout_im,
    output logic                         dout_valid,
    output logic                         sync_out,
    output logic                         warning
);

    import dss_pkg::*;

    // net right shift once SHIFT and the point move are combined
    localparam int RSH       = DIN_POINT - DOUT_POINT - SHIFT;
    localparam int LSH       = (RSH < 0) ? -RSH : 0;
    localparam int DROP      = (RSH > 0) ? RSH : 0;
    localparam int EXT_WIDTH = DIN_WIDTH + LSH;
    localparam int CMP_WIDTH = ((EXT_WIDTH > DOUT_WIDTH) ? EXT_WIDTH : DOUT_WIDTH) + 1;

    localparam logic signed [CMP_WIDTH-1:0] SAT_MAX =
        {{(CMP_WIDTH-DOUT_WIDTH+1){1'b0}}, {(DOUT_WIDTH-1){1'b1}}};
    localparam logic signed [CMP_WIDTH-1:0] SAT_MIN =
        {{(CMP_WIDTH-DOUT_WIDTH+1){1'b1}}, {(DOUT_WIDTH-1){1'b0}}};

    typedef struct packed {
        logic                         sat;
        logic signed [DOUT_WIDTH-1:0] val;
    } cast_t;

    typedef struct packed {
        logic signed [DOUT_WIDTH-1:0] re;
        logic signed [DOUT_WIDTH-1:0] im;
    } out_pair_t;

    function automatic cast_t cast_part(input logic signed [DIN_WIDTH-1:0] x);
        logic signed [EXT_WIDTH-1:0] w;
        logic signed [CMP_WIDTH-1:0] c;
        cast_t                       r;
        w = x;
        w = w <<< LSH;
        // arithmetic shift floors toward minus infinity
        w = w >>> DROP;
        c = w;
        if (c > SAT_MAX) begin
            r.sat = 1'b1;
            r.val = SAT_MAX[DOUT_WIDTH-1:0];
        end else if (c < SAT_MIN) begin
            r.sat = 1'b1;
            r.val = SAT_MIN[DOUT_WIDTH-1:0];
        end else begin
            r.sat = 1'b0;
            r.val = c[DOUT_WIDTH-1:0];
        end
        return r;
    endfunction

    cast_t     re_c;
    cast_t     im_c;
    out_pair_t pair_c;
    out_pair_t pair_q;

    logic [RESIZE_LATENCY-1:0] vld_sr;
    logic [RESIZE_LATENCY-1:0] sync_sr;
    logic [RESIZE_LATENCY-1:0] warn_sr;

    assign re_c   = cast_part(d.re);
    assign im_c   = cast_part(d.im);
    assign pair_c = {re_c.val, im_c.val};

    delay_line #(
        .payload_t (out_pair_t),
        .DEPTH     (RESIZE_LATENCY)
    ) out_dly (
        .clk  (clk),
        .din  (pair_c),
        .dout (pair_q)
    );

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            vld_sr  <= '0;
            sync_sr <= '0;
            warn_sr <= '0;
        end else begin
            vld_sr[0]  <= d.valid;
            sync_sr[0] <= d.sync;
            // only a valid sample can raise the flag
            warn_sr[0] <= d.valid & (re_c.sat | im_c.sat);
            for (int i = 1; i < RESIZE_LATENCY; i++) begin
                vld_sr[i]  <= vld_sr[i-1];
                sync_sr[i] <= sync_sr[i-1];
                warn_sr[i] <= warn_sr[i-1];
            end
        end
    end

    assign dout_re    = pair_q.re;
    assign dout_im    = pair_q.im;
    assign dout_valid = vld_sr[RESIZE_LATENCY-1];
    assign sync_out   = sync_sr[RESIZE_LATENCY-1];
    assign warning    = warn_sr[RESIZE_LATENCY-1];

endmodule

`default_nettype wire

// File: rtl/complex_mult.sv
`default_nettype none

module complex_mult #(
    parameter int DIN_WIDTH   = 16,
    parameter int COEFF_WIDTH = 16
) (
    input  wire                          clk,
    input  wire                          cnt_rst,
    cplx_if.dst                          a,
    input  wire signed [COEFF_WIDTH-1:0] coeff_re,
    input  wire signed [COEFF_WIDTH-1:0] coeff_im,
    cplx_if.src                          p
);

    import dss_pkg::*;

    localparam int PROD_WIDTH = DIN_WIDTH + COEFF_WIDTH;

    logic signed [DIN_WIDTH-1:0]   a_re_q;
    logic signed [DIN_WIDTH-1:0]   a_im_q;
    logic signed [COEFF_WIDTH-1:0] c_re_q;
    logic signed [COEFF_WIDTH-1:0] c_im_q;

    logic signed [PROD_WIDTH-1:0] rr_q;
    logic signed [PROD_WIDTH-1:0] ii_q;
    logic signed [PROD_WIDTH-1:0] ri_q;
    logic signed [PROD_WIDTH-1:0] ir_q;

    // one guard bit for the sum and difference
    logic signed [PROD_WIDTH:0] re_q;
    logic signed [PROD_WIDTH:0] im_q;

    logic [MULT_LATENCY-1:0] vld_sr;
    logic [MULT_LATENCY-1:0] sync_sr;

    always_ff @(posedge clk) begin
        a_re_q <= a.re;
        a_im_q <= a.im;
        c_re_q <= coeff_re;
        c_im_q <= coeff_im;

        rr_q <= a_re_q * c_re_q;
        ii_q <= a_im_q * c_im_q;
        ri_q <= a_re_q * c_im_q;
        ir_q <= a_im_q * c_re_q;

        // (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
        re_q <= rr_q - ii_q;
        im_q <= ri_q + ir_q;
    end

    // valid and sync follow the data stages
    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            vld_sr  <= '0;
            sync_sr <= '0;
        end else begin
            vld_sr[0]  <= a.valid;
            sync_sr[0] <= a.sync;
            for (int i = 1; i < MULT_LATENCY; i++) begin
                vld_sr[i]  <= vld_sr[i-1];
                sync_sr[i] <= sync_sr[i-1];
            end
        end
    end

    assign p.re    = re_q;
    assign p.im    = im_q;
    assign p.valid = vld_sr[MULT_LATENCY-1];
    assign p.sync  = sync_sr[MULT_LATENCY-1];

endmodule

`default_nettype wire

// File: rtl/coeff_ram.sv
`default_nettype none

module coeff_ram #(
    parameter int VECTOR_LEN  = 16,
    parameter int COEFF_WIDTH = 16
) (
    input  wire                               clk,
    input  wire                               we,
    input  wire        [$clog2(VECTOR_LEN)-1:0] waddr,
    input  wire signed [COEFF_WIDTH-1:0]      wdata_re,
    input  wire signed [COEFF_WIDTH-1:0]      wdata_im,
    input  wire        [$clog2(VECTOR_LEN)-1:0] raddr,
    output logic signed [COEFF_WIDTH-1:0]     rdata_re,
    output logic signed [COEFF_WIDTH-1:0]     rdata_im
);

    logic signed [COEFF_WIDTH-1:0] mem_re [VECTOR_LEN];
    logic signed [COEFF_WIDTH-1:0] mem_im [VECTOR_LEN];

    // all bins start with a zero weight
    initial begin
        for (int i = 0; i < VECTOR_LEN; i++) begin
            mem_re[i] = '0;
            mem_im[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (we) begin
            mem_re[waddr] <= wdata_re;
            mem_im[waddr] <= wdata_im;
        end
    end

    // read during write on one address gives the old word
    always_ff @(posedge clk) begin
        rdata_re <= mem_re[raddr];
        rdata_im <= mem_im[raddr];
    end

endmodule

`default_nettype wire

// File: rtl/delay_line.sv
`default_nettype none

module delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  wire      clk,
    input  wire      payload_t din,
    output payload_t dout
);

    payload_t stage [DEPTH];

    always_ff @(posedge clk) begin
        stage[0] <= din;
        for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

// File: rtl/cplx_if.sv
`default_nettype none

interface cplx_if #(
    parameter int WIDTH = 16
) ();

    logic signed [WIDTH-1:0] re;
    logic signed [WIDTH-1:0] im;
    logic                    valid;
    // first bin of a vector
    logic                    sync;

    modport src (
        output re,
        output im,
        output valid,
        output sync
    );

    modport dst (
        input re,
        input im,
        input valid,
        input sync
    );

endinterface

`default_nettype wire

// File: rtl/dss_pkg.sv
`default_nettype none

package dss_pkg;

    // coefficient read, address in to coefficient out
    localparam int READ_LATENCY = 1;

    // operand register, partial products, sum and difference
    localparam int MULT_LATENCY = 3;

    // shift, floor and saturate in one registered stage
    localparam int RESIZE_LATENCY = 1;

    // sample in to weighted sample out
    localparam int PIPE_LATENCY = READ_LATENCY + MULT_LATENCY + RESIZE_LATENCY;

    // input samples, Q1.15
    localparam int default_din_width = 16;
    localparam int default_din_point = 15;

    // coefficients, Q2.14 so that unity gain fits
    localparam int default_coeff_width = 16;
    localparam int default_coeff_point = 14;

    // weighted output, Q1.15
    localparam int default_dout_width = 16;
    localparam int default_dout_point = 15;

endpackage

`default_nettype wire
